// ==== rtl/sprite_pkg.sv ====
// sprite display shared definitions
// coordinate and colour types, config register map, background colour
`default_nettype none

package sprite_pkg;

	// signed screen coordinate, blanking sits below zero
	typedef logic signed [15:0] coord_t;

	typedef logic [11:0] colour_t;  // rgb 4:4:4
	typedef logic [7:0] bmp_row_t;  // one bit per pixel, msb leftmost

	// config port
	typedef logic [3:0] cfg_addr_t;
	typedef logic [15:0] cfg_data_t;

	// config address map, per sprite
	localparam cfg_addr_t CFG_ROW0 = 4'd0;  // bitmap rows, top first
	localparam cfg_addr_t CFG_ROW1 = 4'd1;
	localparam cfg_addr_t CFG_ROW2 = 4'd2;
	localparam cfg_addr_t CFG_ROW3 = 4'd3;
	localparam cfg_addr_t CFG_ROW4 = 4'd4;
	localparam cfg_addr_t CFG_ROW5 = 4'd5;
	localparam cfg_addr_t CFG_ROW6 = 4'd6;
	localparam cfg_addr_t CFG_ROW7 = 4'd7;
	localparam cfg_addr_t CFG_POSX = 4'd8;  // left edge
	localparam cfg_addr_t CFG_POSY = 4'd9;  // top edge
	localparam cfg_addr_t CFG_COLOUR = 4'd10;
	// 11..15 unused, writes dropped

	// unscaled bitmap edge in pixels
	localparam int SPR_SIZE = 8;

	// dark blue behind all sprites
	localparam colour_t BG_COLOUR = 12'h137;

	// per-line engine state
	typedef enum logic {
		IDLE,    // line misses the sprite
		ACTIVE   // line crosses the sprite, row latched
	} spr_state_t;

endpackage

`default_nettype wire

// ==== rtl/display_timing.sv ====
// display timing generator
// signed coordinates with blanking below zero, sync, de, line and frame strobes
`default_nettype none
`timescale 1ns/10ps

module display_timing #(
	parameter int H_RES = 640,   // active pixels per line
	parameter int V_RES = 480,   // active lines
	parameter int H_FP = 16,
	parameter int H_SYNC = 96,
	parameter int H_BP = 48,
	parameter int V_FP = 10,
	parameter int V_SYNC = 2,
	parameter int V_BP = 33
) (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	output sprite_pkg::coord_t tx,  // horizontal position
	output sprite_pkg::coord_t ty,  // vertical position
	output logic t_hsync,
	output logic t_vsync,
	output logic t_de,
	output logic t_line,   // first coordinate of a line
	output logic t_frame   // first coordinate of a frame
);

	import sprite_pkg::*;

	// blanking comes first: fp, sync, bp, then active from 0
	localparam coord_t H_STA = coord_t'(-(H_FP + H_SYNC + H_BP));
	localparam coord_t HS_STA = coord_t'(-(H_SYNC + H_BP));
	localparam coord_t HS_END = coord_t'(-H_BP);
	localparam coord_t HA_END = coord_t'(H_RES - 1);
	localparam coord_t V_STA = coord_t'(-(V_FP + V_SYNC + V_BP));
	localparam coord_t VS_STA = coord_t'(-(V_SYNC + V_BP));
	localparam coord_t VS_END = coord_t'(-V_BP);
	localparam coord_t VA_END = coord_t'(V_RES - 1);

	coord_t x_nxt;
	coord_t y_nxt;

	// next coordinate, wraps at the end of line and frame
	always_comb begin
		x_nxt = tx + coord_t'(1);
		y_nxt = ty;
		if (tx == HA_END) begin
			x_nxt = H_STA;
			y_nxt = (ty == VA_END) ? V_STA : ty + coord_t'(1);
		end
	end

	// flags from the next values, so they line up with tx/ty
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			tx <= H_STA;
			ty <= V_STA;
			t_hsync <= 1'b0;
			t_vsync <= 1'b0;
			t_de <= 1'b0;
			t_line <= 1'b0;
			t_frame <= 1'b0;
		end else begin
			tx <= x_nxt;
			ty <= y_nxt;
			t_hsync <= (x_nxt >= HS_STA) && (x_nxt < HS_END);  // active high
			t_vsync <= (y_nxt >= VS_STA) && (y_nxt < VS_END);
			t_de <= (x_nxt >= 0) && (y_nxt >= 0);
			t_line <= (x_nxt == H_STA);
			t_frame <= (x_nxt == H_STA) && (y_nxt == V_STA);
		end
	end

	// counters never leave their blanking-to-active span
	assert property (@(posedge clk_pix) disable iff (!rst_n)
		(tx >= H_STA) && (tx <= HA_END) && (ty >= V_STA) && (ty <= VA_END))
		else $error("display_timing: coordinate out of range tx=%0d ty=%0d", tx, ty);

endmodule

`default_nettype wire

// ==== rtl/sprite_engine.sv ====
// sprite engine: one 8x8 one-bit bitmap scaled by 2^SPR_SCALE
// row chosen per line, pixel hit found in a two-stage pipeline
`default_nettype none
`timescale 1ns/10ps

module sprite_engine #(
	parameter int NUM_SPR = 4,    // engines sharing the config port
	parameter int SPR_SCALE = 3,  // log2 of scale factor
	parameter int SPR_IDX = 0     // this engine's config select
) (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	input  wire logic cfg_we,
	input  wire logic [$clog2(NUM_SPR)-1:0] cfg_sel,
	input  wire sprite_pkg::cfg_addr_t cfg_addr,
	input  wire sprite_pkg::cfg_data_t cfg_data,
	input  wire sprite_pkg::coord_t tx,
	input  wire sprite_pkg::coord_t ty,
	input  wire logic t_de,
	input  wire logic t_line,
	output logic spr_draw,                  // sprite bit set at coordinate
	output sprite_pkg::colour_t spr_colour  // valid with spr_draw
);

	import sprite_pkg::*;

	localparam int SEL_W = $clog2(NUM_SPR);
	localparam int IDX_W = $clog2(SPR_SIZE);  // bitmap row/column index
	localparam logic [SEL_W-1:0] MY_SEL = SEL_W'(SPR_IDX);
	localparam coord_t SPR_EDGE = coord_t'(SPR_SIZE << SPR_SCALE);  // scaled size

	// config state
	bmp_row_t bmp [SPR_SIZE];
	coord_t posx;
	coord_t posy;
	colour_t spr_col;

	// line state
	spr_state_t state;
	bmp_row_t row_q;  // row for the current line
	coord_t dy;
	coord_t dx;
	logic y_in;
	logic x_in;

	// pixel pipeline
	logic s1_hit;
	logic [IDX_W-1:0] s1_col;
	colour_t s1_colour;

	logic wr;
	assign wr = cfg_we && (cfg_sel == MY_SEL);

	// bitmap rows, loaded at run time
	always_ff @(posedge clk_pix) begin
		if (wr) begin
			case (cfg_addr)
				CFG_ROW0, CFG_ROW1, CFG_ROW2, CFG_ROW3,
				CFG_ROW4, CFG_ROW5, CFG_ROW6, CFG_ROW7:
					bmp[cfg_addr[IDX_W-1:0]] <= cfg_data[SPR_SIZE-1:0];
				default: ;  // position and colour handled below
			endcase
		end
	end

	// position and colour, start off screen and black
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			posx <= -16'sd128;
			posy <= -16'sd128;
			spr_col <= '0;
		end else if (wr) begin
			case (cfg_addr)
				CFG_POSX: posx <= coord_t'(cfg_data);
				CFG_POSY: posy <= coord_t'(cfg_data);
				CFG_COLOUR: spr_col <= cfg_data[11:0];
				default: ;  // rows or unmapped
			endcase
		end
	end

	// vertical test, used only at the line strobe
	always_comb begin
		dy = ty - posy;
		y_in = (dy >= 0) && (dy < SPR_EDGE);
	end

	// decide the line once, so writes mid-line cannot tear it
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			state <= IDLE;
		end else if (t_line) begin
			state <= y_in ? ACTIVE : IDLE;
		end
	end

	always_ff @(posedge clk_pix) begin
		if (t_line && y_in) begin
			row_q <= bmp[dy[SPR_SCALE +: IDX_W]];  // unscaled row
		end
	end

	// horizontal test against the live position
	always_comb begin
		dx = tx - posx;
		x_in = (dx >= 0) && (dx < SPR_EDGE);
	end

	// stage 1: in box, column index
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			s1_hit <= 1'b0;
		end else begin
			s1_hit <= t_de && (state == ACTIVE) && x_in;
		end
	end

	always_ff @(posedge clk_pix) begin
		s1_col <= dx[SPR_SCALE +: IDX_W];
		s1_colour <= spr_col;
	end

	// stage 2: bitmap lookup, msb is column 0
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			spr_draw <= 1'b0;
		end else begin
			spr_draw <= s1_hit && row_q[~s1_col];
		end
	end

	always_ff @(posedge clk_pix) begin
		spr_colour <= s1_colour;
	end

	// drawing only ever follows an active-area coordinate from the timing block
	assert property (@(posedge clk_pix) disable iff (!rst_n)
		spr_draw |-> $past(t_de, 2))
		else $error("sprite_engine %0d: draw outside active area", SPR_IDX);

endmodule

`default_nettype wire

// ==== rtl/sprite_compositor.sv ====
// sprite compositor: lowest-index drawing sprite wins, else background
// timing delayed two cycles to meet the engine outputs, then registered
`default_nettype none
`timescale 1ns/10ps

module sprite_compositor #(
	parameter int NUM_SPR = 4
) (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	input  wire sprite_pkg::coord_t tx,
	input  wire sprite_pkg::coord_t ty,
	input  wire logic t_hsync,
	input  wire logic t_vsync,
	input  wire logic t_de,
	input  wire logic t_frame,
	input  wire logic [NUM_SPR-1:0] spr_draw,
	input  wire sprite_pkg::colour_t [NUM_SPR-1:0] spr_colour,
	output sprite_pkg::coord_t sx,
	output sprite_pkg::coord_t sy,
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic frame,
	output sprite_pkg::colour_t colour
);

	import sprite_pkg::*;

	// two-stage delay, matches the engine pipeline
	coord_t x_d [2];
	coord_t y_d [2];
	logic [3:0] ctl_d [2];  // {hsync, vsync, de, frame}
	colour_t pick;

	always_ff @(posedge clk_pix) begin
		x_d[0] <= tx;
		y_d[0] <= ty;
		x_d[1] <= x_d[0];
		y_d[1] <= y_d[0];
	end

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			ctl_d[0] <= '0;
			ctl_d[1] <= '0;
		end else begin
			ctl_d[0] <= {t_hsync, t_vsync, t_de, t_frame};
			ctl_d[1] <= ctl_d[0];
		end
	end

	// scan high to low so sprite 0 lands last
	always_comb begin
		pick = BG_COLOUR;
		for (int i = NUM_SPR - 1; i >= 0; i--) begin
			if (spr_draw[i]) pick = spr_colour[i];
		end
		if (!ctl_d[1][1]) pick = BG_COLOUR;  // blanking
	end

	always_ff @(posedge clk_pix) begin
		sx <= x_d[1];
		sy <= y_d[1];
	end

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			{hsync, vsync, de, frame} <= '0;
			colour <= BG_COLOUR;
		end else begin
			{hsync, vsync, de, frame} <= ctl_d[1];
			colour <= pick;
		end
	end

	// output de only ever on the visible quadrant
	assert property (@(posedge clk_pix) disable iff (!rst_n)
		de |-> (sx >= 0) && (sy >= 0))
		else $error("sprite_compositor: de high at sx=%0d sy=%0d", sx, sy);

endmodule

`default_nettype wire

// ==== rtl/sprite_display.sv ====
// sprite display top: timing generator, NUM_SPR sprite engines, compositor
// config writes go to every engine, each keeps only its own
`default_nettype none
`timescale 1ns/10ps

module sprite_display #(
	parameter int H_RES = 640,
	parameter int V_RES = 480,
	parameter int H_FP = 16,
	parameter int H_SYNC = 96,
	parameter int H_BP = 48,
	parameter int V_FP = 10,
	parameter int V_SYNC = 2,
	parameter int V_BP = 33,
	parameter int NUM_SPR = 4,
	parameter int SPR_SCALE = 3   // 8x, as on the board build
) (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	input  wire logic cfg_we,
	input  wire logic [$clog2(NUM_SPR)-1:0] cfg_sel,
	input  wire sprite_pkg::cfg_addr_t cfg_addr,
	input  wire sprite_pkg::cfg_data_t cfg_data,
	output sprite_pkg::coord_t sx,
	output sprite_pkg::coord_t sy,
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic frame,
	output sprite_pkg::colour_t colour
);

	import sprite_pkg::*;

	coord_t tx;
	coord_t ty;
	logic t_hsync;
	logic t_vsync;
	logic t_de;
	logic t_line;
	logic t_frame;
	logic [NUM_SPR-1:0] spr_draw;       // one bit per engine
	colour_t [NUM_SPR-1:0] spr_colour;

	display_timing #(
		.H_RES(H_RES), .V_RES(V_RES),
		.H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
	) i_display_timing (
		.clk_pix, .rst_n,
		.tx, .ty, .t_hsync, .t_vsync, .t_de, .t_line, .t_frame
	);

	for (genvar i = 0; i < NUM_SPR; i++) begin : g_spr
		sprite_engine #(
			.NUM_SPR(NUM_SPR), .SPR_SCALE(SPR_SCALE), .SPR_IDX(i)
		) i_sprite_engine (
			.clk_pix, .rst_n,
			.cfg_we, .cfg_sel, .cfg_addr, .cfg_data,
			.tx, .ty, .t_de, .t_line,
			.spr_draw(spr_draw[i]),
			.spr_colour(spr_colour[i])
		);
	end

	sprite_compositor #(.NUM_SPR(NUM_SPR)) i_sprite_compositor (
		.clk_pix, .rst_n,
		.tx, .ty, .t_hsync, .t_vsync, .t_de, .t_frame,
		.spr_draw, .spr_colour,
		.sx, .sy, .hsync, .vsync, .de, .frame, .colour
	);

endmodule

`default_nettype wire

// ==== tests/sprite_model.svh ====
// sprite reference model for the testbench
// mirrors every config write and gives the colour expected at a screen point
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

	// mirrored config state, one entry per engine
	bmp_row_t m_bmp [NUM_SPR][SPR_SIZE];
	coord_t m_posx [NUM_SPR];
	coord_t m_posy [NUM_SPR];
	colour_t m_col [NUM_SPR];

	// scaled box edge in pixels
	localparam coord_t BOX_EDGE = coord_t'(SPR_SIZE << SPR_SCALE);

	// state after reset: parked off screen, black
	function automatic void model_reset();
		for (int i = 0; i < NUM_SPR; i++) begin
			m_posx[i] = coord_t'(-128);
			m_posy[i] = coord_t'(-128);
			m_col[i] = '0;
			for (int r = 0; r < SPR_SIZE; r++) begin
				m_bmp[i][r] = '0;  // off screen anyway
			end
		end
	endfunction

	// same register map as the config port
	function automatic void model_write(int idx, cfg_addr_t addr, cfg_data_t data);
		if (addr <= CFG_ROW7) begin
			m_bmp[idx][addr[2:0]] = bmp_row_t'(data);
		end else if (addr == CFG_POSX) begin
			m_posx[idx] = coord_t'(data);
		end else if (addr == CFG_POSY) begin
			m_posy[idx] = coord_t'(data);
		end else if (addr == CFG_COLOUR) begin
			m_col[idx] = colour_t'(data);
		end
		// unmapped addresses change nothing
	endfunction

	// lowest index with a set bit under the point wins, else background
	function automatic colour_t expected_colour(coord_t x, coord_t y);
		coord_t dx;
		coord_t dy;
		int r;
		int c;
		if (x < coord_t'(0) || y < coord_t'(0)) return BG_COLOUR;  // blanking
		for (int i = 0; i < NUM_SPR; i++) begin
			dx = x - m_posx[i];
			dy = y - m_posy[i];
			if (dx >= coord_t'(0) && dx < BOX_EDGE && dy >= coord_t'(0) && dy < BOX_EDGE) begin
				r = int'(dy) >> SPR_SCALE;  // unscaled row
				c = int'(dx) >> SPR_SCALE;  // unscaled column
				if (m_bmp[i][r][SPR_SIZE - 1 - c]) return m_col[i];  // msb leftmost
			end
		end
		return BG_COLOUR;
	endfunction

`endif

// ==== tests/tb_sprite_display.sv ====
// testbench for the sprite display pipeline
// small frame, three engines at 2x scale, every pixel checked against the model
`default_nettype none
`timescale 1ns/10ps

module tb_sprite_display;

	import sprite_pkg::*;

	localparam int H_RES = 48;
	localparam int V_RES = 32;
	localparam int H_FP = 4;
	localparam int H_SYNC = 4;
	localparam int H_BP = 4;
	localparam int V_FP = 2;
	localparam int V_SYNC = 2;
	localparam int V_BP = 2;
	localparam int NUM_SPR = 3;
	localparam int SPR_SCALE = 1;
	localparam int SEL_W = $clog2(NUM_SPR);
	localparam int FRAME_CYC = (H_RES + H_FP + H_SYNC + H_BP) * (V_RES + V_FP + V_SYNC + V_BP);
	localparam int H_STA = -(H_FP + H_SYNC + H_BP);  // first blanking column
	localparam int V_STA = -(V_FP + V_SYNC + V_BP);  // first blanking line

	`include "sprite_model.svh"

	logic clk_pix;
	logic rst_n;
	logic cfg_we;
	logic [SEL_W-1:0] cfg_sel;
	cfg_addr_t cfg_addr;
	cfg_data_t cfg_data;
	coord_t sx;
	coord_t sy;
	logic hsync;
	logic vsync;
	logic de;
	logic frame;
	colour_t colour;

	int seed;
	logic checking;  // compare armed for one full frame
	logic prev_de = 1'b0;
	coord_t prev_sx = '0;
	coord_t line_sy = '0;  // sy of the last line start
	coord_t lines = '0;    // lines with de in this frame
	coord_t run_len = '0;  // de cycles in this line

	sprite_display #(
		.H_RES(H_RES), .V_RES(V_RES),
		.H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
		.NUM_SPR(NUM_SPR), .SPR_SCALE(SPR_SCALE)
	) i_sprite_display (
		.clk_pix, .rst_n,
		.cfg_we, .cfg_sel, .cfg_addr, .cfg_data,
		.sx, .sy, .hsync, .vsync, .de, .frame, .colour
	);

	initial begin
		clk_pix = 1'b0;
		forever #5 clk_pix = ~clk_pix;  // 100 MHz
	end

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_colour(string name, colour_t got, colour_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h at sx=%0d sy=%0d",
				name, got, exp, sx, sy);
			abort_run();
		end
	endtask

	task automatic check_coord(string name, coord_t got, coord_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h at sx=%0d sy=%0d",
				name, got, exp, sx, sy);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// next output frame pulse, sampled mid-cycle
	task automatic wait_frame();
		int n;
		n = 0;
		@(negedge clk_pix);
		while (frame !== 1'b1 && n < 2 * FRAME_CYC) begin
			n++;
			@(negedge clk_pix);
		end
		if (frame !== 1'b1) begin
			$display("Timeout: no frame pulse within %0d cycles", 2 * FRAME_CYC);
			abort_run();
		end
	endtask

	// one register write, model follows
	task automatic write_cfg(int idx, cfg_addr_t addr, cfg_data_t data);
		@(posedge clk_pix);
		cfg_we <= 1'b1;
		cfg_sel <= SEL_W'(idx);
		cfg_addr <= addr;
		cfg_data <= data;
		@(posedge clk_pix);
		cfg_we <= 1'b0;
		model_write(idx, addr, data);
	endtask

	task automatic move_sprite(int idx, coord_t x, coord_t y);
		write_cfg(idx, CFG_POSX, cfg_data_t'(x));
		write_cfg(idx, CFG_POSY, cfg_data_t'(y));
	endtask

	// random bitmap, then position and colour
	task automatic load_sprite(int idx, coord_t x, coord_t y, colour_t col);
		for (int r = 0; r < SPR_SIZE; r++) begin
			write_cfg(idx, cfg_addr_t'(r), cfg_data_t'(bmp_row_t'($random(seed))));
		end
		move_sprite(idx, x, y);
		write_cfg(idx, CFG_COLOUR, cfg_data_t'(col));
	endtask

	// skip the frame the writes landed in, then check one whole frame
	task automatic check_frame();
		wait_frame();
		wait_frame();
		checking <= 1'b1;
		wait_frame();
		checking <= 1'b0;  // compare still sees this end pulse
	endtask

	// compare process, colour every cycle plus the de/sx/sy shape and strobes
	always @(negedge clk_pix) begin
		coord_t exp_x;
		coord_t exp_y;
		logic exp_hs;
		logic exp_vs;
		exp_x = prev_de ? coord_t'(prev_sx + coord_t'(1)) : coord_t'(0);
		if (de && !prev_de) begin
			exp_y = (lines == coord_t'(0)) ? coord_t'(0)
				: coord_t'(line_sy + coord_t'(1));
		end else begin
			exp_y = line_sy;  // same line
		end
		exp_hs = (sx >= H_STA + H_FP) && (sx < H_STA + H_FP + H_SYNC);  // fp, sync, bp
		exp_vs = (sy >= V_STA + V_FP) && (sy < V_STA + V_FP + V_SYNC);
		if (checking) begin
			check_colour("colour", colour, expected_colour(sx, sy));
			check_bit("de", de, (sx >= 0) && (sy >= 0));
			check_bit("hsync", hsync, exp_hs);
			check_bit("vsync", vsync, exp_vs);
			check_bit("frame", frame, (sx == H_STA) && (sy == V_STA));
			if (de) check_coord("sx", sx, exp_x);
			if (de) check_coord("sy", sy, exp_y);
			if (!de && prev_de) check_coord("de run length", run_len, coord_t'(H_RES));
			if (frame) check_coord("de lines per frame", lines, coord_t'(V_RES));
		end
		if (frame) lines = coord_t'(0);  // new frame
		if (de && !prev_de) begin
			lines = lines + coord_t'(1);
			line_sy = sy;
			run_len = coord_t'(0);
		end
		if (de) run_len = run_len + coord_t'(1);
		prev_de = de;
		prev_sx = sx;
	end

	initial begin
		seed = 32'he58b_b4c2;
		checking = 1'b0;
		rst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_sel = '0;
		cfg_addr = '0;
		cfg_data = '0;
		model_reset();
		repeat (7) @(posedge clk_pix);
		@(negedge clk_pix);  // outputs in reset state by now
		check_bit("de", de, 1'b0);
		check_bit("hsync", hsync, 1'b0);
		check_bit("vsync", vsync, 1'b0);
		check_bit("frame", frame, 1'b0);
		check_colour("colour", colour, BG_COLOUR);
		@(posedge clk_pix);
		rst_n <= 1'b1;  // eighth edge still in reset
		check_frame();  // blank frame and timing shape
		// one sprite anywhere fully on screen
		load_sprite(0, coord_t'($random(seed) & 31), coord_t'($random(seed) & 15), 12'hf80);
		check_frame();
		// overlap, sprite 0 on top
		load_sprite(0, 10, 6, 12'hf00);
		load_sprite(1, 16, 10, 12'h0f0);
		load_sprite(2, 20, 12, 12'h00f);
		check_frame();
		// clipped on the left and bottom, sprite 2 on the right and top
		load_sprite(0, -6, 26, 12'hff0);
		move_sprite(2, 40, -4);
		check_frame();
		// moves between frames
		move_sprite(1, 4, 2);
		check_frame();
		move_sprite(1, 30, 18);
		check_frame();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
rtl/sprite_pkg.sv
rtl/display_timing.sv
rtl/sprite_engine.sv
rtl/sprite_compositor.sv
rtl/sprite_display.sv
tests/tb_sprite_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sprite display testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
	--top-module tb_sprite_display -o tb_sprite_display

status=0
./obj_dir/tb_sprite_display > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"
